// ==== design/apbRegs.sv ====
/*
 * APB register block of the FIR filter.
 * Decodes control, status and the coefficient window. Register accesses
 * finish in their first access cycle, while coefficient accesses become a
 * held request to the shared coefficient store and stretch pReady until
 * the store has answered. Unmapped addresses finish with pSlvErr.
 */

`timescale 1ns/1ps

module apbRegs import firPkg::*; #(
	parameter int TAPS = 16,
	parameter int DATA_WIDTH = 8
) (
	input  logic                        clock,
	input  logic                        rstN,
	input  logic                        pSel,
	input  logic                        pEnable,
	input  logic                        pWrite,
	input  logic [apbAddrWidth-1:0]     pAddr,
	input  logic [apbDataWidth-1:0]     pWData,
	output logic [apbDataWidth-1:0]     pRData,
	output logic                        pReady,
	output logic                        pSlvErr,
	output logic                        hostReq,
	output logic                        hostWrite,
	output logic [$clog2(TAPS)-1:0]     hostAddr,
	output logic [DATA_WIDTH-1:0]       hostWData,
	input  logic                        hostGrant,
	input  logic [DATA_WIDTH-1:0]       hostRData,
	output logic                        enable,
	output logic                        clearLine,
	input  logic                        busy,
	input  logic                        sampleAccepted
);

	localparam int idxBits = $clog2(TAPS);

	logic                    access;
	logic                    isControl;
	logic                    isStatus;
	logic                    isCoeff;
	logic                    readPending;
	logic [apbAddrWidth-1:0] coeffOffset;
	logic [15:0]             sampleCount;

	// The access phase is the second cycle of every APB transfer.
	assign access = pSel && pEnable;

	// Offset into the coefficient window, used for both range check and index.
	assign coeffOffset = pAddr - coeffBase;

	assign isControl = (pAddr == regControl);
	assign isStatus = (pAddr == regStatus);

	// Only word-aligned addresses that land on an existing tap are valid.
	assign isCoeff = (pAddr >= coeffBase) && (coeffOffset[1:0] == 2'b00)
		&& (coeffOffset[apbAddrWidth-1:2] < TAPS);

	// The request stays up until granted. Once a read has its grant, the
	// request drops while the data comes back.
	assign hostReq = access && isCoeff && !readPending;
	assign hostWrite = pWrite;
	assign hostAddr = coeffOffset[idxBits+1:2];
	assign hostWData = pWData[DATA_WIDTH-1:0];

	// A coefficient write finishes on its grant edge.
	// A coefficient read finishes one cycle later, when the data is out.
	assign pReady = access && (isCoeff ? (pWrite ? hostGrant : readPending) : 1'b1);

	assign pSlvErr = access && !(isControl || isStatus || isCoeff);

	// Marks the cycle in which the store's read data is valid for the host.
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			readPending <= 1'b0;
		end else if (readPending) begin
			readPending <= 1'b0;
		end else if (hostReq && hostGrant && !hostWrite) begin
			readPending <= 1'b1;
		end
	end

	// Control register. Clear is a self-clearing pulse toward the delay line.
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			enable <= 1'b0;
			clearLine <= 1'b0;
		end else if (access && pWrite && isControl) begin
			enable <= pWData[0];
			clearLine <= pWData[1];
		end else begin
			clearLine <= 1'b0;
		end
	end

	// Free-running count of accepted samples, wrapping at 16 bits.
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			sampleCount <= '0;
		end else if (sampleAccepted) begin
			sampleCount <= sampleCount + 16'd1;
		end
	end

	// Read data mux. Clear always reads back as zero and unmapped reads return 0.
	always_comb begin
		pRData = '0;
		if (isControl) begin
			pRData[0] = enable;
		end else if (isStatus) begin
			pRData[apbDataWidth-1 -: 16] = sampleCount;
			pRData[0] = busy;
		end else if (isCoeff) begin
			// Coefficients are signed, so the sign bit fills the upper word.
			pRData = {{(apbDataWidth - DATA_WIDTH){hostRData[DATA_WIDTH-1]}}, hostRData};
		end
	end

endmodule

// ==== design/coeffStore.sv ====
/*
 * Coefficient store of the FIR filter.
 * TAPS words of DATA_WIDTH bits shared by the host and the MAC engine.
 * A fixed-priority arbiter always serves the engine first; the host is
 * granted only in cycles without an engine request. Reads take one cycle.
 */

`timescale 1ns/1ps

module coeffStore #(
	parameter int TAPS = 16,
	parameter int DATA_WIDTH = 8
) (
	input  logic                    clock,
	input  logic                    rstN,
	input  logic                    hostReq,
	input  logic                    hostWrite,
	input  logic [$clog2(TAPS)-1:0] hostAddr,
	input  logic [DATA_WIDTH-1:0]   hostWData,
	output logic                    hostGrant,
	output logic [DATA_WIDTH-1:0]   hostRData,
	input  logic                    engReq,
	input  logic [$clog2(TAPS)-1:0] engAddr,
	output logic [DATA_WIDTH-1:0]   engRData
);

	logic [DATA_WIDTH-1:0]   coeffMem [TAPS];
	logic [DATA_WIDTH-1:0]   readData;
	logic [$clog2(TAPS)-1:0] readAddr;

	// The engine never waits, so the host only gets idle cycles.
	assign hostGrant = hostReq && !engReq;

	// Address mux follows the winner of the arbitration.
	assign readAddr = engReq ? engAddr : hostAddr;

	// Host writes commit on the grant edge.
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < TAPS; i++) begin
				coeffMem[i] <= '0;
			end
		end else if (hostGrant && hostWrite) begin
			coeffMem[hostAddr] <= hostWData;
		end
	end

	// One read register serves both ports. It only loads for the port that
	// won, so the host's data survives until the cycle after its grant.
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			readData <= '0;
		end else if (engReq || (hostGrant && !hostWrite)) begin
			readData <= coeffMem[readAddr];
		end
	end

	assign hostRData = readData;
	assign engRData = readData;

endmodule

// ==== design/firPkg.sv ====
/*
 * FIR filter shared definitions.
 * Holds the APB register map, the bus widths and the rule that sizes
 * the full-precision accumulator and output of the filter.
 */

package firPkg;

	// The APB data bus is a full 32-bit word.
	localparam int apbDataWidth = 32;

	// The map spans 4 KB, which is enough for the coefficient window.
	localparam int apbAddrWidth = 12;

	// Control register. Bit 0 is enable, bit 1 is a clear of the sample history.
	localparam logic [apbAddrWidth-1:0] regControl = 12'h000;

	// Status register, read only.
	// Bit 0 is engine busy and the upper half counts accepted samples.
	localparam logic [apbAddrWidth-1:0] regStatus = 12'h004;

	// First coefficient word. Coefficient k sits at coeffBase + 4*k.
	localparam logic [apbAddrWidth-1:0] coeffBase = 12'h100;

	// A product of two samples needs twice the sample width.
	// Summing taps products adds ceil(log2(taps)) bits of growth on top.
	function automatic int accWidth(input int dataWidth, input int taps);
		return 2 * dataWidth + $clog2(taps);
	endfunction

endpackage

// ==== design/firTop.sv ====
/*
 * Streaming FIR filter, top level.
 * Ties the APB register block, the shared coefficient store, the sample
 * delay line and the MAC engine together and hands down TAPS and DATA_WIDTH.
 */

`timescale 1ns/1ps

module firTop import firPkg::*; #(
	parameter int TAPS = 16,
	parameter int DATA_WIDTH = 8
) (
	input  logic                                         clock,
	input  logic                                         rstN,
	input  logic                                         pSel,
	input  logic                                         pEnable,
	input  logic                                         pWrite,
	input  logic [apbAddrWidth-1:0]                      pAddr,
	input  logic [apbDataWidth-1:0]                      pWData,
	output logic [apbDataWidth-1:0]                      pRData,
	output logic                                         pReady,
	output logic                                         pSlvErr,
	input  logic signed [DATA_WIDTH-1:0]                 sampleIn,
	input  logic                                         sampleValid,
	output logic                                         sampleReady,
	output logic signed [accWidth(DATA_WIDTH, TAPS)-1:0] firOut,
	output logic                                         outValid,
	input  logic                                         outReady
);

	logic                         hostReq;
	logic                         hostWrite;
	logic [$clog2(TAPS)-1:0]      hostAddr;
	logic [DATA_WIDTH-1:0]        hostWData;
	logic                         hostGrant;
	logic [DATA_WIDTH-1:0]        hostRData;
	logic                         engReq;
	logic [$clog2(TAPS)-1:0]      engAddr;
	logic [DATA_WIDTH-1:0]        engRData;
	logic                         enable;
	logic                         clearLine;
	logic                         busy;
	logic                         sampleAccepted;
	logic                         shiftIn;
	logic signed [DATA_WIDTH-1:0] shiftData;
	logic [$clog2(TAPS)-1:0]      tapAddr;
	logic signed [DATA_WIDTH-1:0] tapData;

	apbRegs #(.TAPS(TAPS), .DATA_WIDTH(DATA_WIDTH)) uApbRegs (
		.clock, .rstN, .pSel, .pEnable, .pWrite, .pAddr, .pWData, .pRData,
		.pReady, .pSlvErr, .hostReq, .hostWrite, .hostAddr, .hostWData,
		.hostGrant, .hostRData, .enable, .clearLine, .busy, .sampleAccepted
	);

	coeffStore #(.TAPS(TAPS), .DATA_WIDTH(DATA_WIDTH)) uCoeffStore (
		.clock, .rstN, .hostReq, .hostWrite, .hostAddr, .hostWData,
		.hostGrant, .hostRData, .engReq, .engAddr, .engRData
	);

	sampleLine #(.TAPS(TAPS), .DATA_WIDTH(DATA_WIDTH)) uSampleLine (
		.clock, .rstN, .shiftIn, .shiftData, .clearLine, .tapAddr, .tapData
	);

	macEngine #(.TAPS(TAPS), .DATA_WIDTH(DATA_WIDTH)) uMacEngine (
		.clock, .rstN, .enable, .sampleIn, .sampleValid, .sampleReady,
		.shiftIn, .shiftData, .tapAddr, .tapData, .engReq, .engAddr,
		.engRData, .busy, .sampleAccepted, .firOut, .outValid, .outReady
	);

endmodule

// ==== design/macEngine.sv ====
/*
 * Multiply-accumulate engine of the FIR filter.
 * Accepts one sample, shifts it into the delay line and then walks all
 * taps, reading coefficient TAPS-1-k against sample k. Issue, multiply and
 * accumulate are pipelined so that taps overlap. The full-precision sum is
 * presented on the output stream and held until it is taken.
 */

`timescale 1ns/1ps

module macEngine import firPkg::*; #(
	parameter int TAPS = 16,
	parameter int DATA_WIDTH = 8
) (
	input  logic                                          clock,
	input  logic                                          rstN,
	input  logic                                          enable,
	input  logic signed [DATA_WIDTH-1:0]                  sampleIn,
	input  logic                                          sampleValid,
	output logic                                          sampleReady,
	output logic                                          shiftIn,
	output logic signed [DATA_WIDTH-1:0]                  shiftData,
	output logic [$clog2(TAPS)-1:0]                       tapAddr,
	input  logic signed [DATA_WIDTH-1:0]                  tapData,
	output logic                                          engReq,
	output logic [$clog2(TAPS)-1:0]                       engAddr,
	input  logic signed [DATA_WIDTH-1:0]                  engRData,
	output logic                                          busy,
	output logic                                          sampleAccepted,
	output logic signed [accWidth(DATA_WIDTH, TAPS)-1:0]  firOut,
	output logic                                          outValid,
	input  logic                                          outReady
);

	localparam int tapBits = $clog2(TAPS);
	localparam int accW = accWidth(DATA_WIDTH, TAPS);
	localparam logic [tapBits-1:0] lastTap = tapBits'(TAPS - 1);

	logic                           accept;
	logic                           running;
	logic [tapBits-1:0]             tapCount;
	logic                           rdValid;
	logic                           rdLast;
	logic                           prodValid;
	logic                           prodLast;
	logic signed [DATA_WIDTH-1:0]   sampleDly;
	logic signed [2*DATA_WIDTH-1:0] prodReg;
	logic signed [accW-1:0]         acc;

	// Busy covers every pipeline stage, not only the issue cycles.
	assign busy = running || rdValid || prodValid;

	// A new sample is taken only when nothing is in flight or waiting.
	assign sampleReady = enable && !busy && !outValid;
	assign accept = sampleValid && sampleReady;
	assign sampleAccepted = accept;

	// The sample enters the line on its accept edge, so tap 0 is already
	// the newest sample in the first issue cycle.
	assign shiftIn = accept;
	assign shiftData = sampleIn;

	// Sample k pairs with coefficient TAPS-1-k.
	assign tapAddr = tapCount;
	assign engReq = running;
	assign engAddr = lastTap - tapCount;

	// Issue stage. One tap per cycle for TAPS cycles after an accept.
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			running <= 1'b0;
			tapCount <= '0;
		end else if (accept) begin
			running <= 1'b1;
			tapCount <= '0;
		end else if (running) begin
			if (tapCount == lastTap) begin
				running <= 1'b0;
				tapCount <= '0;
			end else begin
				tapCount <= tapCount + 1'b1;
			end
		end
	end

	// Valid and last flags follow the data through the read and multiply stages.
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			rdValid <= 1'b0;
			rdLast <= 1'b0;
			prodValid <= 1'b0;
			prodLast <= 1'b0;
		end else begin
			rdValid <= running;
			rdLast <= running && (tapCount == lastTap);
			prodValid <= rdValid;
			prodLast <= rdLast;
		end
	end

	// The sample is delayed one stage to line up with the coefficient,
	// which comes back from the store a cycle after the request.
	always_ff @(posedge clock) begin
		sampleDly <= tapData;
		prodReg <= engRData * sampleDly;
	end

	// Accumulator. It doubles as the output register, and stays still
	// while the result waits, since no new sample can start.
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			acc <= '0;
		end else if (accept) begin
			acc <= '0;
		end else if (prodValid) begin
			acc <= acc + prodReg;
		end
	end

	// The last product lands on the same edge that raises outValid.
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			outValid <= 1'b0;
		end else if (prodValid && prodLast) begin
			outValid <= 1'b1;
		end else if (outReady) begin
			outValid <= 1'b0;
		end
	end

	assign firOut = acc;

endmodule

// ==== design/sampleLine.sv ====
/*
 * Sample delay line of the FIR filter.
 * Keeps the last TAPS samples, newest at tap 0, and offers any tap on
 * a combinational read port. A clear zeroes the whole history.
 */

`timescale 1ns/1ps

module sampleLine #(
	parameter int TAPS = 16,
	parameter int DATA_WIDTH = 8
) (
	input  logic                         clock,
	input  logic                         rstN,
	input  logic                         shiftIn,
	input  logic signed [DATA_WIDTH-1:0] shiftData,
	input  logic                         clearLine,
	input  logic [$clog2(TAPS)-1:0]      tapAddr,
	output logic signed [DATA_WIDTH-1:0] tapData
);

	logic signed [DATA_WIDTH-1:0] taps [TAPS];

	// Clear wins over a shift arriving on the same edge.
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < TAPS; i++) begin
				taps[i] <= '0;
			end
		end else if (clearLine) begin
			for (int i = 0; i < TAPS; i++) begin
				taps[i] <= '0;
			end
		end else if (shiftIn) begin
			// Older samples move one place toward the end of the line.
			for (int i = TAPS - 1; i > 0; i--) begin
				taps[i] <= taps[i-1];
			end
			taps[0] <= shiftData;
		end
	end

	// The engine reads the tap it needs in the same cycle it asks for it.
	assign tapData = taps[tapAddr];

endmodule

// ==== project.f ====
design/firPkg.sv
design/apbRegs.sv
design/coeffStore.sv
design/sampleLine.sv
design/macEngine.sv
design/firTop.sv
tests/firTb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the FIR testbench with Verilator, runs it and looks for the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module firTb -f project.f -o firSim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/firSim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "ALL CHECKS PASSED"; then
	exit 0
fi
echo "Pass line not found in the simulation output"
exit 1

// ==== tests/firTb.sv ====
/*
 * Self-checking testbench for the streaming FIR filter.
 * Programs coefficients over APB, streams random samples with random
 * back-pressure and compares every output with a convolution model.
 * Also checks latency, output hold, shared memory access and the status count.
 */

`timescale 1ns/1ps

module firTb import firPkg::*;;

	localparam int TAPS = 16;
	localparam int DATA_WIDTH = 8;
	localparam int accW = accWidth(DATA_WIDTH, TAPS);
	localparam int streamSamples = 200;
	localparam int loadSamples = 60;
	localparam int clearSamples = 20;
	localparam int totalSamples = streamSamples + loadSamples + clearSamples;
	// Each sample gets a generous per-sample budget, plus room for the APB-only tests.
	localparam int watchdogCycles = totalSamples * (TAPS + 8) + 2000;

	logic                          clock;
	logic                          rstN;
	logic                          pSel;
	logic                          pEnable;
	logic                          pWrite;
	logic [apbAddrWidth-1:0]       pAddr;
	logic [apbDataWidth-1:0]       pWData;
	logic [apbDataWidth-1:0]       pRData;
	logic                          pReady;
	logic                          pSlvErr;
	logic signed [DATA_WIDTH-1:0]  sampleIn;
	logic                          sampleValid;
	logic                          sampleReady;
	logic signed [accW-1:0]        firOut;
	logic                          outValid;
	logic                          outReady;

	// Reference model state, shared by the monitor and the test sequence.
	logic signed [DATA_WIDTH-1:0]  history [TAPS];
	logic signed [DATA_WIDTH-1:0]  coefModel [TAPS];
	logic signed [accW-1:0]        expQ [$];
	logic signed [accW-1:0]        heldOut;
	int                            cycle;
	int                            acceptCycle;
	int                            acceptCount;
	int                            outCount;
	int                            checkCount;
	int                            errorCount;
	logic                          waitingOut;
	logic                          outValidPrev;
	logic                          stalledPrev;

	firTop #(.TAPS(TAPS), .DATA_WIDTH(DATA_WIDTH)) u_dut (
		.clock, .rstN, .pSel, .pEnable, .pWrite, .pAddr, .pWData, .pRData,
		.pReady, .pSlvErr, .sampleIn, .sampleValid, .sampleReady, .firOut,
		.outValid, .outReady
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	// Compares one value with its expected value and reports a mismatch at once.
	task automatic checkValue(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		checkCount++;
		if (got !== exp) begin
			errorCount++;
			$display("MISMATCH %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
		end
	endtask

	// One APB transfer. Inputs change on falling edges; pReady is looked at
	// a little after the edge, once everything has settled.
	task automatic apbTransfer(input logic write, input logic [apbAddrWidth-1:0] addr,
		input logic [apbDataWidth-1:0] wdata, output logic [apbDataWidth-1:0] rdata,
		output logic slvErr);
		@(negedge clock);
		pSel = 1'b1;
		pEnable = 1'b0;
		pWrite = write;
		pAddr = addr;
		pWData = wdata;
		@(negedge clock);
		pEnable = 1'b1;
		#10;
		while (!pReady) begin
			@(negedge clock);
			#10;
		end
		rdata = pRData;
		slvErr = pSlvErr;
		@(negedge clock);
		pSel = 1'b0;
		pEnable = 1'b0;
		pWrite = 1'b0;
	endtask

	// Reads one register and checks both the data and a clean response.
	task automatic readExpect(input string name, input logic [apbAddrWidth-1:0] addr,
		input logic [apbDataWidth-1:0] exp);
		logic [apbDataWidth-1:0] rdata;
		logic                    err;
		apbTransfer(1'b0, addr, '0, rdata, err);
		checkValue(name, rdata, exp);
		checkValue({name, " pSlvErr"}, err, 1'b0);
	endtask

	// Sum over k of history[k] times coefficient TAPS-1-k, at full precision.
	function automatic logic signed [accW-1:0] modelOutput();
		longint sum;
		sum = 0;
		for (int k = 0; k < TAPS; k++) begin
			sum += longint'(history[k]) * longint'(coefModel[TAPS-1-k]);
		end
		return accW'(sum);
	endfunction

	// Offers samples with random idle gaps, holding each until it is taken.
	task automatic sendSamples(input int count);
		int gap;
		@(negedge clock);
		for (int i = 0; i < count; i++) begin
			gap = $urandom % 4;
			sampleValid = 1'b0;
			repeat (gap) @(negedge clock);
			sampleValid = 1'b1;
			sampleIn = DATA_WIDTH'($urandom);
			#10;
			while (!sampleReady) begin
				@(negedge clock);
				#10;
			end
			@(negedge clock);
		end
		sampleValid = 1'b0;
	endtask

	// Toggles outReady at random until the wanted number of outputs is in.
	task automatic drainOutputs(input int target);
		while (outCount < target) begin
			@(negedge clock);
			outReady = $urandom % 2;
		end
		outReady = 1'b0;
	endtask

	// APB reads of random taps while the engine keeps the store busy.
	task automatic readCoeffsLive(input int count);
		int k;
		for (int i = 0; i < count; i++) begin
			repeat ($urandom % 8) @(negedge clock);
			k = $urandom % TAPS;
			readExpect("live coefficient", coeffBase + 12'(4 * k), 32'(coefModel[k]));
		end
	endtask

	task automatic finishTest(input string name, input int startErrors);
		$display("Test %s finished with %0d errors", name, errorCount - startErrors);
	endtask

	// Monitor. It samples shortly after each falling edge, which is what the
	// DUT will see on the next rising edge.
	initial begin
		forever begin
			@(negedge clock);
			#10;
			cycle++;
			if (sampleValid && sampleReady) begin
				for (int k = TAPS - 1; k > 0; k--) begin
					history[k] = history[k-1];
				end
				history[0] = sampleIn;
				expQ.push_back(modelOutput());
				acceptCycle = cycle;
				acceptCount++;
				waitingOut = 1'b1;
			end
			// The rising edge before this sample point is cycle-1, the accept edge
			// was the one after acceptCycle.
			if (outValid && !outValidPrev && waitingOut) begin
				checkValue("accept-to-outValid cycles", cycle - acceptCycle - 1, TAPS + 2);
				waitingOut = 1'b0;
			end
			if (outValid && stalledPrev) begin
				checkValue("firOut held", firOut, heldOut);
			end
			if (outValid && outReady) begin
				if (expQ.size() == 0) begin
					errorCount++;
					$display("An output arrived with no accepted sample waiting for it");
				end else begin
					checkValue("firOut", firOut, expQ.pop_front());
				end
				outCount++;
			end
			stalledPrev = outValid && !outReady;
			heldOut = firOut;
			outValidPrev = outValid;
		end
	end

	initial begin
		repeat (watchdogCycles) @(posedge clock);
		$display("Timeout: the run did not finish within %0d cycles", watchdogCycles);
		$display("CHECKS FAILED");
		$finish;
	end

	initial begin
		int                      testStart;
		int                      target;
		logic [apbDataWidth-1:0] rdata;
		logic [apbDataWidth-1:0] wdata;
		logic                    err;
		void'($urandom(32'ha5ca));
		rstN = 1'b0;
		pSel = 1'b0;
		pEnable = 1'b0;
		pWrite = 1'b0;
		pAddr = '0;
		pWData = '0;
		sampleIn = '0;
		sampleValid = 1'b0;
		outReady = 1'b0;
		for (int k = 0; k < TAPS; k++) begin
			history[k] = '0;
			coefModel[k] = '0;
		end
		repeat (2) @(posedge clock);
		@(negedge clock);
		rstN = 1'b1;

		// Everything comes out of reset idle and zeroed.
		testStart = errorCount;
		@(negedge clock);
		#10;
		checkValue("outValid", outValid, 1'b0);
		checkValue("sampleReady", sampleReady, 1'b0);
		readExpect("control", regControl, '0);
		readExpect("status", regStatus, '0);
		for (int k = 0; k < TAPS; k++) begin
			readExpect("reset coefficient", coeffBase + 12'(4 * k), '0);
		end
		finishTest("reset state", testStart);

		// Only the low DATA_WIDTH bits are kept, and they read back sign-extended.
		testStart = errorCount;
		for (int k = 0; k < TAPS; k++) begin
			wdata = $urandom;
			coefModel[k] = wdata[DATA_WIDTH-1:0];
			apbTransfer(1'b1, coeffBase + 12'(4 * k), wdata, rdata, err);
			checkValue("coefficient write pSlvErr", err, 1'b0);
		end
		for (int k = 0; k < TAPS; k++) begin
			readExpect("coefficient", coeffBase + 12'(4 * k), 32'(coefModel[k]));
		end
		finishTest("coefficient readback", testStart);

		testStart = errorCount;
		apbTransfer(1'b1, regControl, 32'h1, rdata, err);
		target = outCount + streamSamples;
		fork
			sendSamples(streamSamples);
			drainOutputs(target);
		join
		checkValue("outputs left over", expQ.size(), 0);
		finishTest("random streaming", testStart);

		testStart = errorCount;
		target = outCount + loadSamples;
		fork
			sendSamples(loadSamples);
			drainOutputs(target);
			readCoeffsLive(12);
		join
		checkValue("outputs left over", expQ.size(), 0);
		finishTest("shared memory under load", testStart);

		// Clear keeps enable set, so the stream can go on right away.
		testStart = errorCount;
		apbTransfer(1'b1, regControl, 32'h3, rdata, err);
		for (int k = 0; k < TAPS; k++) begin
			history[k] = '0;
		end
		target = outCount + clearSamples;
		fork
			sendSamples(clearSamples);
			drainOutputs(target);
		join
		checkValue("outputs left over", expQ.size(), 0);
		readExpect("control after clear", regControl, 32'h1);
		readExpect("status count", regStatus, {16'(acceptCount), 16'h0000});
		apbTransfer(1'b0, 12'h050, '0, rdata, err);
		checkValue("bad address read data", rdata, '0);
		checkValue("bad address read pSlvErr", err, 1'b1);
		// Bit 0 is low here, so a write that leaked into control would drop enable.
		apbTransfer(1'b1, 12'h050, 32'hffff_fffe, rdata, err);
		checkValue("bad address write pSlvErr", err, 1'b1);
		readExpect("control after bad write", regControl, 32'h1);
		finishTest("clear, count and bad address", testStart);

		$display("Tests run: 5, checks: %0d, failures: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule
